// File: sim.f
+incdir+src
src/tlb_pkg.sv
src/walk_if.sv
src/page_walker.sv
src/tlb.sv
src/xlate_top.sv
dv/mem_model.sv
dv/xlate_tb.sv

// File: Makefile
# Verilator build and run for the translation unit testbench

VERILATOR ?= verilator
TOP       ?= xlate_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/xlate_tb.sv
// xlate_tb module: clock, reset, directed and random requests, reference model and assertions
`timescale 1ns/100ps
`default_nettype none
`include "tlb_config.svh"

module xlate_tb;
	import tlb_pkg::*;

	localparam logic [31:0] SEED = 32'h6970800e;
	localparam int RANDOM_REQS = 280;
	localparam int CYCLE_LIMIT = 40000; // ~300 requests, 9 slow reads at worst
	localparam paddr_t PTBR = 48'h0000_8000_0000;

	logic clk = 1'b0;
	logic reset;
	logic req_valid;
	logic req_ready;
	vaddr_t req_vaddr;
	logic resp_valid;
	logic resp_ready = 1'b0;
	paddr_t resp_paddr;
	logic resp_fault;
	logic flush;
	paddr_t ptbr;
	logic mem_req_valid;
	logic mem_req_ready;
	paddr_t mem_req_addr;
	logic mem_resp_valid;
	pte_t mem_resp_data;

	logic [1:0][`TLB_SETS-1:0] ref_valid;
	tlb_tag_t ref_tag [2][`TLB_SETS];
	logic [`TLB_SETS-1:0] ref_lru; // way to replace next
	vpn_t req_vpn;
	logic [`TLB_INDEX_W-1:0] req_idx;
	tlb_tag_t req_tag;
	logic hit0;
	logic hit1;
	logic pred_hit;
	logic req_fire;
	logic resp_fire;
	logic mem_fire;

	paddr_t exp_paddr;
	logic exp_fault;
	int exp_reads;
	int reads_seen;
	int open_reqs;
	logic [1:0] want; // 1 hit, 2 miss
	logic [31:0] rnd;
	logic [31:0] stall_rnd;
	int cycle_cnt = 0;

	always #50 clk = ~clk;

	xlate_top dut (
		.clk            (clk),
		.reset          (reset),
		.req_valid      (req_valid),
		.req_ready      (req_ready),
		.req_vaddr      (req_vaddr),
		.resp_valid     (resp_valid),
		.resp_ready     (resp_ready),
		.resp_paddr     (resp_paddr),
		.resp_fault     (resp_fault),
		.flush          (flush),
		.ptbr           (ptbr),
		.mem_req_valid  (mem_req_valid),
		.mem_req_ready  (mem_req_ready),
		.mem_req_addr   (mem_req_addr),
		.mem_resp_valid (mem_resp_valid),
		.mem_resp_data  (mem_resp_data)
	);

	mem_model #(.SEED(SEED)) u_mem (
		.clk            (clk),
		.reset          (reset),
		.ptbr           (ptbr),
		.mem_req_valid  (mem_req_valid),
		.mem_req_ready  (mem_req_ready),
		.mem_req_addr   (mem_req_addr),
		.mem_resp_valid (mem_resp_valid),
		.mem_resp_data  (mem_resp_data)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic vaddr_t make_vaddr(input int region, input int low, input int offset);
		return {18'(region), 18'(low), 12'(offset)};
	endfunction

	function automatic logic l1_fault(input vaddr_t va);
		return (va[47:30] % 18'd7) == 18'd6;
	endfunction

	function automatic logic expected_fault(input vaddr_t va);
		return l1_fault(va) || ((va[47:12] % 36'd13) == 36'd12);
	endfunction

	function automatic paddr_t expected_paddr(input vaddr_t va);
		return expected_fault(va) ? '0 : {va[47:12] ^ 36'h5A5A5, va[11:0]};
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1);
	endtask

	assign req_vpn = req_vaddr[47:12];
	assign req_idx = req_vpn[8:3];
	assign req_tag = req_vpn[35:9];
	assign hit0 = ref_valid[0][req_idx] && (ref_tag[0][req_idx] == req_tag);
	assign hit1 = ref_valid[1][req_idx] && (ref_tag[1][req_idx] == req_tag);
	assign pred_hit = hit0 || hit1;
	assign req_fire = req_valid && req_ready && !flush;
	assign resp_fire = resp_valid && resp_ready;
	assign mem_fire = mem_req_valid && mem_req_ready;

	// reference TLB contents and the expectation for the request in flight
	always @(posedge clk) begin
		if (reset) begin
			ref_valid <= '0;
			ref_lru <= '0;
			exp_paddr <= '0;
			exp_fault <= 1'b0;
			exp_reads <= 0;
			reads_seen <= 0;
			open_reqs <= 0;
		end else begin
			if (mem_fire)
				reads_seen <= reads_seen + 1;
			if (resp_fire)
				open_reqs <= open_reqs - 1;
			if (flush && req_ready) begin
				ref_valid <= '0;
				ref_lru <= '0;
			end else if (req_fire) begin
				open_reqs <= open_reqs + 1;
				reads_seen <= 0;
				exp_paddr <= expected_paddr(req_vaddr);
				exp_fault <= expected_fault(req_vaddr);
				if (pred_hit) begin
					exp_reads <= 0;
					ref_lru[req_idx] <= !hit1;
				end else if (l1_fault(req_vaddr)) begin
					exp_reads <= 1; // nothing filled
				end else begin
					exp_reads <= 9;
					ref_valid[ref_lru[req_idx]][req_idx] <= 1'b1;
					ref_tag[ref_lru[req_idx]][req_idx] <= req_tag;
					ref_lru[req_idx] <= !ref_lru[req_idx];
				end
			end
		end
	end

	// random resp_ready stalls, also between requests
	always @(posedge clk) begin
		if (reset) begin
			stall_rnd <= SEED;
			resp_ready <= 1'b0;
		end else begin
			stall_rnd <= lcg_next(stall_rnd);
			resp_ready <= stall_rnd[31:30] != 2'b00; // stall one cycle in four
		end
	end

	paddr_a: assert property (@(posedge clk) disable iff (reset)
		resp_fire |-> resp_paddr == exp_paddr)
		else abort_run($sformatf("Mismatch at %0t: paddr %h, expected %h",
			$time, $sampled(resp_paddr), $sampled(exp_paddr)));

	fault_a: assert property (@(posedge clk) disable iff (reset)
		resp_fire |-> resp_fault == exp_fault)
		else abort_run($sformatf("Mismatch at %0t: fault %b, expected %b",
			$time, $sampled(resp_fault), $sampled(exp_fault)));

	reads_a: assert property (@(posedge clk) disable iff (reset)
		resp_fire |-> reads_seen == exp_reads)
		else abort_run($sformatf("Mismatch at %0t: %0d memory reads, expected %0d",
			$time, $sampled(reads_seen), $sampled(exp_reads)));

	hit_latency_a: assert property (@(posedge clk) disable iff (reset)
		req_fire && pred_hit |=> resp_valid)
		else abort_run($sformatf("Mismatch at %0t: hit response not after one cycle", $time));

	resp_hold_a: assert property (@(posedge clk) disable iff (reset)
		resp_valid && !resp_ready |=>
			resp_valid && $stable(resp_paddr) && $stable(resp_fault))
		else abort_run($sformatf("Mismatch at %0t: stalled response changed", $time));

	no_accept_a: assert property (@(posedge clk) disable iff (reset)
		resp_valid |-> !req_ready)
		else abort_run("A request could be accepted while a response was waiting");

	single_a: assert property (@(posedge clk) disable iff (reset)
		req_fire |-> open_reqs == 0)
		else abort_run("A second request was accepted before the first was answered");

	owned_a: assert property (@(posedge clk) disable iff (reset)
		resp_fire |-> open_reqs == 1)
		else abort_run("A response came with no request outstanding");

	scenario_a: assert property (@(posedge clk) disable iff (reset)
		req_fire && want != 2'd0 |-> pred_hit == (want == 2'd1))
		else abort_run($sformatf("Mismatch at %0t: hit or miss not as the scenario needs",
			$time));

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT)
			abort_run("Timeout: the run did not finish within the cycle limit");
	end

	task automatic send(input vaddr_t va, input logic [1:0] expect_kind);
		@(posedge clk);
		req_valid <= 1'b1;
		req_vaddr <= va;
		want <= expect_kind;
		@(posedge clk);
		while (!req_ready)
			@(posedge clk);
		want <= 2'd0;
		do begin
			@(posedge clk); // req_valid stays high while the response is due
		end while (!(resp_valid && resp_ready));
		req_valid <= 1'b0;
	endtask

	task automatic pulse_flush();
		@(posedge clk);
		flush <= 1'b1;
		@(posedge clk);
		flush <= 1'b0;
	endtask

	task automatic random_requests(input int count);
		int region;
		int low;
		int offset;
		repeat (count) begin
			rnd = lcg_next(rnd);
			region = int'(rnd[31:28]);
			rnd = lcg_next(rnd);
			low = int'(rnd[31:23]); // stays inside vpn bits 8:0
			rnd = lcg_next(rnd);
			offset = int'(rnd[31:20]);
			send(make_vaddr(region, low, offset), 2'd0);
		end
	endtask

	initial begin
		rnd = SEED;
		reset <= 1'b1;
		req_valid <= 1'b0;
		req_vaddr <= '0;
		flush <= 1'b0;
		ptbr <= PTBR;
		want <= 2'd0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		// first pte misses, the rest of its line hits
		send(make_vaddr(1, 40, 12'h123), 2'd2);
		for (int k = 1; k < 8; k++)
			send(make_vaddr(1, 40 + k, k * 16), 2'd1);

		// a, b and c share set 9
		send(make_vaddr(2, 72, 0), 2'd2);
		send(make_vaddr(3, 72, 0), 2'd2);
		send(make_vaddr(2, 72, 8), 2'd1);
		send(make_vaddr(4, 72, 0), 2'd2);
		send(make_vaddr(2, 72, 16), 2'd1);
		send(make_vaddr(3, 72, 4), 2'd2);

		pulse_flush();
		send(make_vaddr(2, 72, 0), 2'd2);
		send(make_vaddr(2, 73, 0), 2'd1);

		// level-1 entry invalid, so the line is never filled
		send(make_vaddr(6, 100, 0), 2'd2);
		send(make_vaddr(6, 100, 0), 2'd2);

		random_requests(RANDOM_REQS);
		repeat (2) @(posedge clk);
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/mem_model.sv
// mem_model module: page table memory with random ready stalls and response delays
`timescale 1ns/100ps
`default_nettype none

module mem_model #(
	parameter logic [31:0] SEED = 32'h1
) (
	input  logic            clk,
	input  logic            reset,
	input  tlb_pkg::paddr_t ptbr,
	input  logic            mem_req_valid,
	output logic            mem_req_ready,
	input  tlb_pkg::paddr_t mem_req_addr,
	output logic            mem_resp_valid,
	output tlb_pkg::pte_t   mem_resp_data
);
	import tlb_pkg::*;

	localparam paddr_t L1_SPAN = 48'h20_0000; // 2^18 level-1 entries

	logic [31:0] rnd;
	logic busy;
	logic [2:0] delay;
	pte_t data_q;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// level-2 tables sit at page 256+r, only vpn bits 8:0 used below region
	function automatic pte_t table_word(input paddr_t addr, input paddr_t base);
		logic [17:0] region;
		logic [8:0] low;
		vpn_t vpn;
		ppn_t ppn;
		if (addr >= base && addr < base + L1_SPAN) begin
			region = 18'((addr - base) >> 3);
			ppn = ppn_t'(region) + 36'd256;
			return {16'h0, ppn, 11'h0, 1'((region % 18'd7) != 18'd6)};
		end
		region = 18'((addr >> 12) - 48'd256);
		low = addr[11:3];
		vpn = {region, 9'h0, low};
		ppn = vpn ^ 36'h5A5A5;
		return {16'h0, ppn, 11'h0, 1'((vpn % 36'd13) != 36'd12)};
	endfunction

	always @(posedge clk) begin
		if (reset) begin
			rnd <= SEED;
			busy <= 1'b0;
			delay <= '0;
			mem_req_ready <= 1'b0;
			mem_resp_valid <= 1'b0;
			mem_resp_data <= '0;
		end else begin
			rnd <= lcg_next(rnd);
			mem_resp_valid <= 1'b0;
			if (mem_req_valid && mem_req_ready) begin
				busy <= 1'b1;
				mem_req_ready <= 1'b0; // one read at a time
				delay <= rnd[30:28]; // 1 to 8 cycles
				data_q <= table_word(mem_req_addr, ptbr);
			end else if (busy) begin
				if (delay == 3'd0) begin
					busy <= 1'b0;
					mem_resp_valid <= 1'b1;
					mem_resp_data <= data_q;
				end else begin
					delay <= delay - 3'd1;
				end
			end else begin
				mem_req_ready <= rnd[27:26] != 2'b00; // stall one cycle in four
			end
		end
	end

endmodule

`default_nettype wire

// File: src/xlate_top.sv
// xlate_top module: translation unit top level with plain request, response and memory ports
`timescale 1ns/100ps
`default_nettype none

module xlate_top (
	input  logic            clk,
	input  logic            reset,
	input  logic            req_valid,
	output logic            req_ready,
	input  tlb_pkg::vaddr_t req_vaddr,
	output logic            resp_valid,
	input  logic            resp_ready,
	output tlb_pkg::paddr_t resp_paddr,
	output logic            resp_fault,
	input  logic            flush,
	input  tlb_pkg::paddr_t ptbr, // level-1 table base
	output logic            mem_req_valid,
	input  logic            mem_req_ready,
	output tlb_pkg::paddr_t mem_req_addr,
	input  logic            mem_resp_valid,
	input  tlb_pkg::pte_t   mem_resp_data
);

	tlb u_tlb (
		.clk            (clk),
		.reset          (reset),
		.req_valid      (req_valid),
		.req_ready      (req_ready),
		.req_vaddr      (req_vaddr),
		.resp_valid     (resp_valid),
		.resp_ready     (resp_ready),
		.resp_paddr     (resp_paddr),
		.resp_fault     (resp_fault),
		.flush          (flush),
		.ptbr           (ptbr),
		.mem_req_valid  (mem_req_valid),
		.mem_req_ready  (mem_req_ready),
		.mem_req_addr   (mem_req_addr),
		.mem_resp_valid (mem_resp_valid),
		.mem_resp_data  (mem_resp_data)
	);

endmodule

`default_nettype wire

// File: src/tlb.sv
// tlb module: two-way set-associative PTE line TLB with LRU, fill, flush and walker
`timescale 1ns/100ps
`default_nettype none
`include "tlb_config.svh"

module tlb (
	input  logic            clk,
	input  logic            reset,
	input  logic            req_valid,
	output logic            req_ready,
	input  tlb_pkg::vaddr_t req_vaddr,
	output logic            resp_valid,
	input  logic            resp_ready,
	output tlb_pkg::paddr_t resp_paddr,
	output logic            resp_fault,
	input  logic            flush,
	input  tlb_pkg::paddr_t ptbr,
	output logic            mem_req_valid,
	input  logic            mem_req_ready,
	output tlb_pkg::paddr_t mem_req_addr,
	input  logic            mem_resp_valid,
	input  tlb_pkg::pte_t   mem_resp_data
);
	import tlb_pkg::*;

	localparam int WAYS = 2;

	tlb_state_t state;
	logic [WAYS-1:0][`TLB_SETS-1:0] valid_q;
	logic [`TLB_SETS-1:0] lru_q; // way to replace next
	logic walk_pending;

	tlb_tag_t tag_mem [WAYS][`TLB_SETS];
	pte_line_t line_mem [WAYS][`TLB_SETS];

	vaddr_t vaddr_q; // request being walked
	logic victim_q;

	vpn_t req_vpn;
	logic [`TLB_INDEX_W-1:0] req_idx;
	logic [`LINE_OFF_W-1:0] req_off;
	tlb_tag_t req_tag;
	vpn_t miss_vpn;
	logic [`TLB_INDEX_W-1:0] miss_idx;
	logic [`LINE_OFF_W-1:0] miss_off;
	tlb_tag_t miss_tag;

	logic hit0;
	logic hit1;
	logic hit;
	logic hit_way;
	pte_t hit_pte;
	pte_t fill_pte;
	logic accept;
	logic do_flush;
	logic fill_ok;

	walk_if walk ();

	page_walker u_walker (
		.clk            (clk),
		.reset          (reset),
		.walk           (walk.walker),
		.ptbr           (ptbr),
		.mem_req_valid  (mem_req_valid),
		.mem_req_ready  (mem_req_ready),
		.mem_req_addr   (mem_req_addr),
		.mem_resp_valid (mem_resp_valid),
		.mem_resp_data  (mem_resp_data)
	);

	function automatic pte_t pick_pte(input pte_line_t line,
		input logic [`LINE_OFF_W-1:0] off);
		return line[off*64 +: 64];
	endfunction

	// ppn of a valid pte joined with the page offset, zero otherwise
	function automatic paddr_t xlate(input pte_t pte, input vaddr_t va);
		ppn_t ppn;
		ppn = pte[`PA_W-1:`PAGE_OFFSET_W];
		return pte[0] ? {ppn, va[`PAGE_OFFSET_W-1:0]} : '0;
	endfunction

	assign req_vpn = req_vaddr[`VA_W-1:`PAGE_OFFSET_W];
	assign req_off = req_vpn[`LINE_OFF_W-1:0];
	assign req_idx = req_vpn[`LINE_OFF_W +: `TLB_INDEX_W];
	assign req_tag = req_vpn[`VPN_W-1 -: `TLB_TAG_W];

	assign miss_vpn = vaddr_q[`VA_W-1:`PAGE_OFFSET_W];
	assign miss_off = miss_vpn[`LINE_OFF_W-1:0];
	assign miss_idx = miss_vpn[`LINE_OFF_W +: `TLB_INDEX_W];
	assign miss_tag = miss_vpn[`VPN_W-1 -: `TLB_TAG_W];

	assign hit0 = valid_q[0][req_idx] && (tag_mem[0][req_idx] == req_tag);
	assign hit1 = valid_q[1][req_idx] && (tag_mem[1][req_idx] == req_tag);
	assign hit = hit0 || hit1;
	assign hit_way = hit1;
	assign hit_pte = pick_pte(line_mem[hit_way][req_idx], req_off);
	assign fill_pte = pick_pte(walk.fill_line, miss_off);

	assign req_ready = (state == IDLE);
	assign resp_valid = (state == RESP);
	assign do_flush = flush && req_ready;
	assign accept = req_valid && req_ready && !flush; // flush wins
	assign fill_ok = (state == WALK) && walk.fill_valid && !walk.fill_fault;

	assign walk.walk_valid = walk_pending;
	assign walk.walk_vpn = miss_vpn;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			valid_q <= '0;
			lru_q <= '0;
			walk_pending <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (do_flush) begin
						valid_q <= '0;
						lru_q <= '0;
					end else if (accept) begin
						if (hit) begin
							lru_q[req_idx] <= !hit_way;
							state <= RESP;
						end else begin
							walk_pending <= 1'b1;
							state <= WALK;
						end
					end
				end
				WALK: begin
					if (walk.walk_valid && walk.walk_ready)
						walk_pending <= 1'b0;
					if (fill_ok) begin
						valid_q[victim_q][miss_idx] <= 1'b1;
						lru_q[miss_idx] <= !victim_q;
					end
					if (walk.fill_valid)
						state <= RESP;
				end
				RESP: begin
					if (resp_ready)
						state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			vaddr_q <= req_vaddr;
			victim_q <= lru_q[req_idx];
		end
		if (accept && hit) begin
			resp_paddr <= xlate(hit_pte, req_vaddr);
			resp_fault <= !hit_pte[0];
		end
		if (state == WALK && walk.fill_valid) begin
			resp_paddr <= walk.fill_fault ? '0 : xlate(fill_pte, vaddr_q);
			resp_fault <= walk.fill_fault || !fill_pte[0];
		end
	end

	always_ff @(posedge clk) begin
		if (fill_ok) begin
			tag_mem[victim_q][miss_idx] <= miss_tag;
			line_mem[victim_q][miss_idx] <= walk.fill_line;
		end
	end

	// fills only go to a line that missed in both ways
	one_way_hit_a: assert property (@(posedge clk) disable iff (reset)
		accept |-> !(hit0 && hit1));

	resp_stable_a: assert property (@(posedge clk) disable iff (reset)
		resp_valid && !resp_ready |=>
			resp_valid && $stable(resp_paddr) && $stable(resp_fault));

endmodule

`default_nettype wire

// File: src/page_walker.sv
// page_walker module: two-level table walk, level-1 entry then one level-2 PTE line
`timescale 1ns/100ps
`default_nettype none
`include "tlb_config.svh"

module page_walker (
	input  logic            clk,
	input  logic            reset,
	walk_if.walker          walk,
	input  tlb_pkg::paddr_t ptbr,
	output logic            mem_req_valid,
	input  logic            mem_req_ready,
	output tlb_pkg::paddr_t mem_req_addr,
	input  logic            mem_resp_valid,
	input  tlb_pkg::pte_t   mem_resp_data
);
	import tlb_pkg::*;

	localparam int WORD_OFF_W = 3; // 8 bytes per pte
	localparam int L2_IDX_W = `VPN_W - `L1_VPN_W - `LINE_OFF_W;

	walk_state_t state;
	logic [`LINE_OFF_W-1:0] word_cnt;
	logic fault_q;

	vpn_t vpn_q;
	ppn_t l2_ppn_q; // level-2 table page
	pte_line_t line_q;

	logic [`L1_VPN_W-1:0] l1_idx;
	logic [L2_IDX_W-1:0] l2_idx;
	paddr_t l1_addr;
	paddr_t l2_addr;

	assign l1_idx = vpn_q[`VPN_W-1 -: `L1_VPN_W];
	assign l2_idx = vpn_q[`VPN_W-`L1_VPN_W-1:`LINE_OFF_W];

	assign l1_addr = ptbr + paddr_t'({l1_idx, {WORD_OFF_W{1'b0}}});
	// line base plus word k of the line
	assign l2_addr = {l2_ppn_q, {`PAGE_OFFSET_W{1'b0}}}
		+ paddr_t'({l2_idx, word_cnt, {WORD_OFF_W{1'b0}}});

	assign mem_req_valid = (state == L1_REQ) || (state == L2_REQ);
	assign mem_req_addr = (state == L1_REQ) ? l1_addr : l2_addr;

	assign walk.walk_ready = (state == W_IDLE);
	assign walk.fill_valid = (state == DONE);
	assign walk.fill_line = line_q;
	assign walk.fill_fault = fault_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= W_IDLE;
			word_cnt <= '0;
			fault_q <= 1'b0;
		end else begin
			case (state)
				W_IDLE: begin
					if (walk.walk_valid) begin
						fault_q <= 1'b0;
						state <= L1_REQ;
					end
				end
				L1_REQ: begin
					if (mem_req_ready)
						state <= L1_WAIT;
				end
				L1_WAIT: begin
					if (mem_resp_valid) begin
						if (!mem_resp_data[0]) begin // no level-2 table
							fault_q <= 1'b1;
							state <= DONE;
						end else begin
							word_cnt <= '0;
							state <= L2_REQ;
						end
					end
				end
				L2_REQ: begin
					if (mem_req_ready)
						state <= L2_WAIT;
				end
				L2_WAIT: begin
					if (mem_resp_valid) begin
						word_cnt <= word_cnt + 1'b1;
						if (&word_cnt)
							state <= DONE;
						else
							state <= L2_REQ;
					end
				end
				DONE: begin
					state <= W_IDLE;
				end
				default: begin
					state <= W_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (walk.walk_valid && walk.walk_ready)
			vpn_q <= walk.walk_vpn;
		if (state == L1_WAIT && mem_resp_valid)
			l2_ppn_q <= mem_resp_data[`PA_W-1:`PAGE_OFFSET_W];
		if (state == L2_WAIT && mem_resp_valid)
			line_q[word_cnt*64 +: 64] <= mem_resp_data;
	end

	// request held with its address until the memory takes it
	req_held_a: assert property (@(posedge clk) disable iff (reset)
		mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr));

	// single outstanding read, so a response only lands in a wait state
	resp_expected_a: assert property (@(posedge clk) disable iff (reset)
		mem_resp_valid |-> (state == L1_WAIT) || (state == L2_WAIT));

endmodule

`default_nettype wire

// File: src/walk_if.sv
// walk_if interface: walk request, fill line and fault between TLB and walker
`timescale 1ns/100ps
`default_nettype none

interface walk_if;
	import tlb_pkg::*;

	logic      walk_valid;
	logic      walk_ready; // walker idle
	vpn_t      walk_vpn;
	logic      fill_valid; // one cycle at end of walk
	pte_line_t fill_line;
	logic      fill_fault; // level-1 entry invalid, nothing to fill

	modport tlb (
		output walk_valid,
		output walk_vpn,
		input  walk_ready,
		input  fill_valid,
		input  fill_line,
		input  fill_fault
	);

	modport walker (
		input  walk_valid,
		input  walk_vpn,
		output walk_ready,
		output fill_valid,
		output fill_line,
		output fill_fault
	);

endinterface

`default_nettype wire

// File: src/tlb_pkg.sv
// tlb_pkg: address, pte and tag typedefs plus the TLB and walker state enums
`default_nettype none
`include "tlb_config.svh"

package tlb_pkg;

	typedef logic [`VA_W-1:0] vaddr_t;
	typedef logic [`PA_W-1:0] paddr_t;
	typedef logic [`VPN_W-1:0] vpn_t;
	typedef logic [`PPN_W-1:0] ppn_t;

	// bit 0 valid, ppn in 47:12, same layout at both levels
	typedef logic [63:0] pte_t;
	typedef logic [64*`PTES_PER_LINE-1:0] pte_line_t; // pte k at 64k

	typedef logic [`TLB_TAG_W-1:0] tlb_tag_t;

	typedef enum logic [1:0] {
		IDLE,
		WALK,
		RESP
	} tlb_state_t;

	typedef enum logic [2:0] {
		W_IDLE,
		L1_REQ,
		L1_WAIT,
		L2_REQ,
		L2_WAIT,
		DONE
	} walk_state_t;

endpackage

`default_nettype wire

// File: src/tlb_config.svh
// translation unit macros: TLB geometry, page size, address widths and VPN split
`ifndef TLB_CONFIG_SVH
`define TLB_CONFIG_SVH

`define TLB_SETS      64
`define TLB_INDEX_W   6
`define PTES_PER_LINE 8
`define LINE_OFF_W    3 // pte select within a line

`define PAGE_OFFSET_W 12
`define VA_W          48
`define PA_W          48

`define VPN_W         (`VA_W - `PAGE_OFFSET_W)
`define PPN_W         (`PA_W - `PAGE_OFFSET_W)
`define TLB_TAG_W     (`VPN_W - `TLB_INDEX_W - `LINE_OFF_W)

// top vpn bits index the level-1 table, the rest pick the level-2 entry
`define L1_VPN_W      18

`endif
